//--- design/ib_config.svh
`ifndef IB_CONFIG_SVH
`define IB_CONFIG_SVH

// Buffer entries, must stay a power of two
`define IB_DEPTH 16

// Slots per cycle on each side
`define IB_FETCH_W 3
`define IB_DECODE_W 3

// Instruction and PC field width
`define IB_XLEN 32

// RV32I addi x0, x0, 0
`define IB_NOP 32'h0000_0013

`endif

//--- design/ib_pkg.sv
`default_nettype none

`include "ib_config.svh"

package ib_pkg;

    // Entry payload fields
    typedef logic [`IB_XLEN-1:0] instr_t;
    typedef logic [`IB_XLEN-1:0] pc_t;

    // One bit per slot
    typedef logic [`IB_FETCH_W-1:0] fetch_mask_t;
    typedef logic [`IB_DECODE_W-1:0] decode_mask_t;

    // Ring index and occupancy, occupancy one bit wider to reach full
    typedef logic [$clog2(`IB_DEPTH)-1:0] ptr_t;
    typedef logic [$clog2(`IB_DEPTH):0] occ_t;

    // Per-cycle write or read count, 0 to 3
    typedef logic [1:0] slot_cnt_t;

endpackage

`default_nettype wire

//--- design/ib_fetch_pack.sv
`default_nettype none

`include "ib_config.svh"

module ib_fetch_pack import ib_pkg::*; (
    input  fetch_mask_t fetch_valid_i,
    input  instr_t      fetch_instr_i [`IB_FETCH_W],
    input  pc_t         fetch_pc_i [`IB_FETCH_W],
    input  logic        fetch_pred_i [`IB_FETCH_W],
    output instr_t      packed_instr_o [`IB_FETCH_W],
    output pc_t         packed_pc_o [`IB_FETCH_W],
    output logic        packed_pred_o [`IB_FETCH_W],
    output slot_cnt_t   wr_count_o
);

    //////////////////////////////////////////////////
    // Compaction of sparse fetch slots
    //////////////////////////////////////////////////

    always_comb begin : pack
        slot_cnt_t pos;

        pos = '0;

        // Unused positions read as zero
        for (int k = 0; k < `IB_FETCH_W; k++) begin
            packed_instr_o[k] = '0;
            packed_pc_o[k]    = '0;
            packed_pred_o[k]  = 1'b0;
        end

        // Lowest valid slot lands in entry 0, the rest follow in slot order
        for (int k = 0; k < `IB_FETCH_W; k++) begin
            if (fetch_valid_i[k]) begin
                packed_instr_o[pos] = fetch_instr_i[k];
                packed_pc_o[pos]    = fetch_pc_i[k];
                packed_pred_o[pos]  = fetch_pred_i[k];
                pos = pos + slot_cnt_t'(1);
            end
        end

        // pos has counted every valid slot by now
        wr_count_o = pos;
    end

endmodule

`default_nettype wire

//--- design/ib_ring_store.sv
`default_nettype none

`include "ib_config.svh"

module ib_ring_store import ib_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      flush_i,
    input  instr_t    packed_instr_i [`IB_FETCH_W],
    input  pc_t       packed_pc_i [`IB_FETCH_W],
    input  logic      packed_pred_i [`IB_FETCH_W],
    input  slot_cnt_t wr_count_i,
    input  slot_cnt_t rd_count_i,
    output instr_t    win_instr_o [`IB_DECODE_W],
    output pc_t       win_pc_o [`IB_DECODE_W],
    output logic      win_pred_o [`IB_DECODE_W],
    output occ_t      occupancy_o,
    output logic      fetch_ready_o
);

    // Entry fields
    instr_t instr_mem [`IB_DEPTH];
    pc_t    pc_mem [`IB_DEPTH];
    logic   pred_mem [`IB_DEPTH];

    // Ring control
    ptr_t head;
    ptr_t tail;
    occ_t count;

    occ_t      free_cnt;
    slot_cnt_t wr_accept;

    //////////////////////////////////////////////////
    // Back-pressure
    //////////////////////////////////////////////////

    assign free_cnt = occ_t'(`IB_DEPTH) - count;

    // Room for a full fetch group is required, whatever the mask
    assign fetch_ready_o = !flush_i && (free_cnt >= occ_t'(`IB_FETCH_W));

    assign wr_accept = fetch_ready_o ? wr_count_i : '0;

    //////////////////////////////////////////////////
    // Storage write
    //////////////////////////////////////////////////

    // Packed entries go to tail, tail+1, tail+2; ptr_t wraps by itself
    always_ff @(posedge clk) begin
        for (int k = 0; k < `IB_FETCH_W; k++) begin
            if (slot_cnt_t'(k) < wr_accept) begin
                instr_mem[tail + ptr_t'(k)] <= packed_instr_i[k];
                pc_mem[tail + ptr_t'(k)]    <= packed_pc_i[k];
                pred_mem[tail + ptr_t'(k)]  <= packed_pred_i[k];
            end
        end
    end

    //////////////////////////////////////////////////
    // Pointers and occupancy
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush_i) begin
            // Drop everything, including this cycle's traffic
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + ptr_t'(rd_count_i);
            tail  <= tail + ptr_t'(wr_accept);
            count <= count + occ_t'(wr_accept) - occ_t'(rd_count_i);
        end
    end

    // Oldest entries, valid only up to count
    always_comb begin
        for (int j = 0; j < `IB_DECODE_W; j++) begin
            win_instr_o[j] = instr_mem[head + ptr_t'(j)];
            win_pc_o[j]    = pc_mem[head + ptr_t'(j)];
            win_pred_o[j]  = pred_mem[head + ptr_t'(j)];
        end
    end

    assign occupancy_o = count;

endmodule

`default_nettype wire

//--- design/ib_issue_select.sv
`default_nettype none

`include "ib_config.svh"

module ib_issue_select import ib_pkg::*; (
    input  logic         flush_i,
    input  decode_mask_t decode_ready_i,
    input  occ_t         occupancy_i,
    input  instr_t       win_instr_i [`IB_DECODE_W],
    input  pc_t          win_pc_i [`IB_DECODE_W],
    input  logic         win_pred_i [`IB_DECODE_W],
    output decode_mask_t decode_valid_o,
    output instr_t       decode_instr_o [`IB_DECODE_W],
    output pc_t          decode_pc_o [`IB_DECODE_W],
    output logic         decode_pred_o [`IB_DECODE_W],
    output slot_cnt_t    rd_count_o
);

    //////////////////////////////////////////////////
    // Grant and route
    //////////////////////////////////////////////////

    always_comb begin : select
        slot_cnt_t below;
        slot_cnt_t granted;

        below   = '0;
        granted = '0;

        for (int k = 0; k < `IB_DECODE_W; k++) begin
            // Idle slot
            decode_valid_o[k] = 1'b0;
            decode_instr_o[k] = `IB_NOP;
            decode_pc_o[k]    = '0;
            decode_pred_o[k]  = 1'b0;

            if (decode_ready_i[k]) begin
                // Ready slots below k already took window entries 0..below-1
                if (!flush_i && (occupancy_i > occ_t'(below))) begin
                    decode_valid_o[k] = 1'b1;
                    decode_instr_o[k] = win_instr_i[below];
                    decode_pc_o[k]    = win_pc_i[below];
                    decode_pred_o[k]  = win_pred_i[below];
                    granted = granted + slot_cnt_t'(1);
                end
                below = below + slot_cnt_t'(1);
            end
        end

        // Head advances by the number of grants
        rd_count_o = granted;
    end

endmodule

`default_nettype wire

//--- design/ib_top.sv
`default_nettype none

`include "ib_config.svh"

module ib_top import ib_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         flush_i,
    // Fetch side
    input  fetch_mask_t  fetch_valid_i,
    input  instr_t       fetch_instr_i [`IB_FETCH_W],
    input  pc_t          fetch_pc_i [`IB_FETCH_W],
    input  logic         fetch_pred_i [`IB_FETCH_W],
    output logic         fetch_ready_o,
    // Decode side
    input  decode_mask_t decode_ready_i,
    output decode_mask_t decode_valid_o,
    output instr_t       decode_instr_o [`IB_DECODE_W],
    output pc_t          decode_pc_o [`IB_DECODE_W],
    output logic         decode_pred_o [`IB_DECODE_W],
    // Status
    output logic         empty_o,
    output occ_t         occupancy_o
);

    // Fetch path
    instr_t    packed_instr [`IB_FETCH_W];
    pc_t       packed_pc [`IB_FETCH_W];
    logic      packed_pred [`IB_FETCH_W];
    slot_cnt_t wr_count;

    // Decode path
    instr_t    win_instr [`IB_DECODE_W];
    pc_t       win_pc [`IB_DECODE_W];
    logic      win_pred [`IB_DECODE_W];
    occ_t      occupancy;
    slot_cnt_t rd_count;

    ib_fetch_pack u_fetch_pack (
        .fetch_valid_i  (fetch_valid_i),
        .fetch_instr_i  (fetch_instr_i),
        .fetch_pc_i     (fetch_pc_i),
        .fetch_pred_i   (fetch_pred_i),
        .packed_instr_o (packed_instr),
        .packed_pc_o    (packed_pc),
        .packed_pred_o  (packed_pred),
        .wr_count_o     (wr_count)
    );

    ib_ring_store u_ring_store (
        .clk (clk), .reset (reset), .flush_i (flush_i),
        .packed_instr_i (packed_instr), .packed_pc_i (packed_pc),
        .packed_pred_i  (packed_pred), .wr_count_i (wr_count), .rd_count_i (rd_count),
        .win_instr_o (win_instr), .win_pc_o (win_pc), .win_pred_o (win_pred),
        .occupancy_o (occupancy), .fetch_ready_o (fetch_ready_o)
    );

    ib_issue_select u_issue_select (
        .flush_i (flush_i), .decode_ready_i (decode_ready_i), .occupancy_i (occupancy),
        .win_instr_i (win_instr), .win_pc_i (win_pc), .win_pred_i (win_pred),
        .decode_valid_o (decode_valid_o), .decode_instr_o (decode_instr_o),
        .decode_pc_o (decode_pc_o), .decode_pred_o (decode_pred_o), .rd_count_o (rd_count)
    );

    assign occupancy_o = occupancy;
    assign empty_o     = (occupancy == '0);

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    // Period of 4 time units
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Reset held low for the first 4 cycles
    initial begin
        reset = 1'b0;
        repeat (4) @(posedge clk);
        reset <= 1'b1;
    end

endmodule

`default_nettype wire

//--- testbench/ib_properties.sv
`default_nettype none

`include "ib_config.svh"

module ib_properties import ib_pkg::*; (
    input logic         clk,
    input logic         reset,
    input logic         flush_i,
    input decode_mask_t decode_ready_i,
    input decode_mask_t decode_valid_o,
    input logic         fetch_ready_o,
    input occ_t         occupancy_o
);

    // No grant on a slot that is not ready
    a_valid_needs_ready: assert property (@(posedge clk) disable iff (!reset)
        (decode_valid_o & ~decode_ready_i) == '0)
        else $error("decode_valid_o set on a slot without decode_ready_i");

    a_occ_bound: assert property (@(posedge clk) disable iff (!reset)
        occupancy_o <= occ_t'(`IB_DEPTH))
        else $error("occupancy_o above buffer depth");

    a_flush_blocks_fetch: assert property (@(posedge clk) disable iff (!reset)
        flush_i |-> !fetch_ready_o)
        else $error("fetch_ready_o high during flush");

    // Flush empties the ring in one edge
    a_flush_empties: assert property (@(posedge clk) disable iff (!reset)
        flush_i |=> occupancy_o == '0)
        else $error("occupancy_o not zero after flush");

endmodule

bind ib_top ib_properties u_properties (.*);

`default_nettype wire

//--- testbench/tb_ib.sv
`default_nettype none

`include "ib_config.svh"

module tb_ib import ib_pkg::*; ();

    localparam int N_SPARSE = 30;
    localparam int N_PARTIAL = 50;
    localparam int N_BACKP = 8;
    localparam int N_FLUSH = 10;
    localparam int N_MIX = 250;
    localparam int DRAIN_MAX = 20;
    localparam int TOTAL_CYCLES = 6 + N_SPARSE + N_PARTIAL + N_BACKP + 1 + 6 + N_FLUSH
                                + N_MIX + 5 * DRAIN_MAX;
    localparam int WATCHDOG_TIME = TOTAL_CYCLES * 4 + 200;
    // Fill stops at the first multiple of three that leaves fewer than three free
    localparam int BACKP_OCC = ((`IB_DEPTH - `IB_FETCH_W) / `IB_FETCH_W + 1) * `IB_FETCH_W;

    logic         clk;
    logic         reset;
    logic         flush;
    logic         fetch_ready;
    logic         empty;
    logic         fetch_pred [`IB_FETCH_W];
    fetch_mask_t  fetch_valid;
    instr_t       fetch_instr [`IB_FETCH_W];
    pc_t          fetch_pc [`IB_FETCH_W];
    decode_mask_t decode_ready, decode_valid;
    instr_t       decode_instr [`IB_DECODE_W];
    pc_t          decode_pc [`IB_DECODE_W];
    logic         decode_pred [`IB_DECODE_W];
    occ_t         occupancy;

    // Reference model, oldest entry at index 0
    instr_t q_instr [$];
    pc_t    q_pc [$];
    logic   q_pred [$];
    pc_t    pc_next;
    int     errors = 0;
    int     checks = 0;

    tb_clock_gen u_clock_gen (.clk (clk), .reset (reset));

    ib_top DUT (
        .clk (clk), .reset (reset), .flush_i (flush),
        .fetch_valid_i (fetch_valid), .fetch_instr_i (fetch_instr), .fetch_pc_i (fetch_pc),
        .fetch_pred_i (fetch_pred), .fetch_ready_o (fetch_ready),
        .decode_ready_i (decode_ready), .decode_valid_o (decode_valid),
        .decode_instr_o (decode_instr), .decode_pc_o (decode_pc),
        .decode_pred_o (decode_pred), .empty_o (empty), .occupancy_o (occupancy)
    );

    //////////////////////////////////////////////////
    // Reference and compare tasks
    //////////////////////////////////////////////////

    // Slot k is granted if ready and the model holds more entries than ready slots below k
    function automatic decode_mask_t expected_valid(int occ, decode_mask_t rdy, logic fl);
        decode_mask_t v;
        int below;
        v = '0;
        below = 0;
        for (int k = 0; k < `IB_DECODE_W; k++) begin
            if (rdy[k]) begin
                if (!fl && occ > below) v[k] = 1'b1;
                below++;
            end
        end
        return v;
    endfunction

    task automatic check_mask(string name, decode_mask_t got, decode_mask_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_instr(string name, instr_t got, instr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_pc(string name, pc_t got, pc_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_occ(string name, occ_t got, occ_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    // Checks before each edge, then the model takes the same edge
    always @(negedge clk) begin : compare
        decode_mask_t exp_v;
        logic exp_ready;
        int nq;
        int n;
        if (reset) begin
            nq = q_instr.size();
            exp_ready = !flush && ((`IB_DEPTH - nq) >= `IB_FETCH_W);
            exp_v = expected_valid(nq, decode_ready, flush);
            check_occ("occupancy_o", occupancy, occ_t'(nq));
            check_bit("empty_o", empty, nq == 0);
            check_bit("fetch_ready_o", fetch_ready, exp_ready);
            check_mask("decode_valid_o", decode_valid, exp_v);
            n = 0;
            for (int k = 0; k < `IB_DECODE_W; k++) begin
                if (exp_v[k]) begin
                    check_instr($sformatf("decode_instr_o[%0d]", k), decode_instr[k], q_instr[n]);
                    check_pc($sformatf("decode_pc_o[%0d]", k), decode_pc[k], q_pc[n]);
                    check_bit($sformatf("decode_pred_o[%0d]", k), decode_pred[k], q_pred[n]);
                    n++;
                end else begin
                    check_instr($sformatf("decode_instr_o[%0d]", k), decode_instr[k], `IB_NOP);
                    check_pc($sformatf("decode_pc_o[%0d]", k), decode_pc[k], '0);
                    check_bit($sformatf("decode_pred_o[%0d]", k), decode_pred[k], 1'b0);
                end
            end
            if (flush) begin
                q_instr.delete();
                q_pc.delete();
                q_pred.delete();
            end else begin
                repeat (n) begin
                    void'(q_instr.pop_front());
                    void'(q_pc.pop_front());
                    void'(q_pred.pop_front());
                end
                for (int k = 0; k < `IB_FETCH_W; k++) begin
                    if (exp_ready && fetch_valid[k]) begin
                        q_instr.push_back(fetch_instr[k]);
                        q_pc.push_back(fetch_pc[k]);
                        q_pred.push_back(fetch_pred[k]);
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    // One cycle of inputs, fresh payload on every fetch slot
    task automatic drive(logic fl, fetch_mask_t fv, decode_mask_t dr);
        logic [31:0] r;
        @(posedge clk);
        flush <= fl;
        fetch_valid <= fv;
        decode_ready <= dr;
        for (int k = 0; k < `IB_FETCH_W; k++) begin
            r = $urandom;
            fetch_instr[k] <= r;
            fetch_pc[k] <= pc_next;
            pc_next = pc_next + pc_t'(4);
            r = $urandom;
            fetch_pred[k] <= r[0];
        end
    endtask

    // First idle cycle lets the last offered fetch group land before empty is looked at
    task automatic drain();
        int n;
        n = 0;
        do begin
            drive(1'b0, '0, '1);
            @(negedge clk);
            n++;
        end while (!empty && n < DRAIN_MAX);
        if (!empty) begin
            errors++;
            $display("Buffer did not drain within %0d cycles", DRAIN_MAX);
        end
    endtask

    task automatic finish_test(string name, int err_before);
        $display("%s finished with %0d errors", name, errors - err_before);
    endtask

    initial begin : watchdog
        #(WATCHDOG_TIME);
        $display("Timeout: run still going after %0d time units", WATCHDOG_TIME);
        $display("Test FAILED");
        $finish;
    end

    initial begin : main
        logic [31:0] r;
        int e;
        void'($urandom(32'ha5c5_1e67));
        flush = 1'b0;
        fetch_valid = '0;
        decode_ready = '0;
        pc_next = 32'h0000_1000;
        for (int k = 0; k < `IB_FETCH_W; k++) begin
            fetch_instr[k] = '0;
            fetch_pc[k] = '0;
            fetch_pred[k] = 1'b0;
        end
        @(posedge reset);

        e = errors;
        repeat (2) drive(1'b0, '0, '0);
        finish_test("reset_state", e);

        e = errors;
        repeat (N_SPARSE) drive(1'b0, fetch_mask_t'($urandom), '1);
        drain();
        finish_test("sparse_fetch", e);

        e = errors;
        repeat (N_PARTIAL) drive(1'b0, fetch_mask_t'($urandom), decode_mask_t'($urandom));
        drain();
        finish_test("partial_decode", e);

        e = errors;
        repeat (N_BACKP) drive(1'b0, '1, '0);
        @(negedge clk);
        check_occ("occupancy_o", occupancy, occ_t'(BACKP_OCC));
        check_bit("fetch_ready_o", fetch_ready, 1'b0);
        drain();
        finish_test("back_pressure", e);

        e = errors;
        repeat (4) drive(1'b0, '1, 3'b001);
        drive(1'b1, '1, '1);
        drive(1'b0, '0, '0);
        @(negedge clk);
        check_occ("occupancy_o", occupancy, '0);
        check_bit("empty_o", empty, 1'b1);
        repeat (N_FLUSH) drive(1'b0, fetch_mask_t'($urandom), decode_mask_t'($urandom));
        drain();
        finish_test("flush", e);

        e = errors;
        repeat (N_MIX) begin
            r = $urandom;
            drive(r[3:0] == 4'd0, fetch_mask_t'($urandom), decode_mask_t'($urandom));
        end
        drain();
        finish_test("random_mix", e);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+design
design/ib_pkg.sv
design/ib_fetch_pack.sv
design/ib_ring_store.sv
design/ib_issue_select.sv
design/ib_top.sv
testbench/tb_clock_gen.sv
testbench/ib_properties.sv
testbench/tb_ib.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the instruction buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f compile.f --top-module tb_ib \
    -Mdir obj_dir -o Vtb_ib
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_ib > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Test OK" "$LOG"; then
    exit 0
else
    echo "Pass message not found in $LOG"
    exit 1
fi
